// File: borrow_select_subtractor.sv
`timescale 1ns/1ps
`default_nettype none

`include "field_settings.svh"

module borrow_select_subtractor (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,
	input  field_pkg::operand_pair_t  ops,
	output field_pkg::field_word_t    diff,
	output logic                      borrow,
	output logic                      done
);

	logic [`WORD_BITS-1:0]  diff0 [`FIELD_WORDS];   // No borrow in
	logic [`WORD_BITS-1:0]  diff1 [`FIELD_WORDS];   // Borrow in
	logic [`FIELD_WORDS-1:0] bout0;
	logic [`FIELD_WORDS-1:0] bout1;
	logic                   busy;
	logic [`FIELD_BITS-1:0] sel_diff;
	logic                   sel_borrow;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else if (start) begin
			busy <= 1'b1;
			done <= 1'b0;
		end else if (busy) begin
			busy <= 1'b0;
			done <= 1'b1;
		end
	end

	// ====================
	// Per-limb differences
	// ====================
	always_ff @(posedge clk) begin
		if (start) begin
			for (int i = 0; i < `FIELD_WORDS; i++) begin
				{bout0[i], diff0[i]} <= {1'b0, ops.x[i*`WORD_BITS +: `WORD_BITS]}
					- {1'b0, ops.y[i*`WORD_BITS +: `WORD_BITS]};
				{bout1[i], diff1[i]} <= {1'b0, ops.x[i*`WORD_BITS +: `WORD_BITS]}
					- {1'b0, ops.y[i*`WORD_BITS +: `WORD_BITS]} - 1'b1;
			end
		end
		if (busy) begin
			diff   <= sel_diff;
			borrow <= sel_borrow;     // Set when x < y
		end
	end

	// ====================
	// Borrow select chain
	// ====================
	always_comb begin
		logic b;
		b = 1'b0;
		for (int i = 0; i < `FIELD_WORDS; i++) begin
			sel_diff[i*`WORD_BITS +: `WORD_BITS] = b ? diff1[i] : diff0[i];
			b = b ? bout1[i] : bout0[i];
		end
		sel_borrow = b;
	end

endmodule

`default_nettype wire

// File: carry_select_adder.sv
`timescale 1ns/1ps
`default_nettype none

`include "field_settings.svh"

module carry_select_adder (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  field_pkg::add_req_t  req,
	output field_pkg::add_sum_t  sum,
	output logic                 done
);

	logic [`WORD_BITS:0]    sum0 [`FIELD_WORDS];    // Limb sum for carry in 0
	logic [`WORD_BITS:0]    sum1 [`FIELD_WORDS];    // Limb sum for carry in 1
	logic                   carry_in_q;
	logic                   busy;
	logic [`FIELD_BITS-1:0] sel_sum;
	logic                   sel_carry;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else if (start) begin
			busy <= 1'b1;
			done <= 1'b0;
		end else if (busy) begin
			busy <= 1'b0;
			done <= 1'b1;
		end
	end

	// First cycle, both limb sums
	always_ff @(posedge clk) begin
		if (start) begin
			carry_in_q <= req.carry_in;
			for (int i = 0; i < `FIELD_WORDS; i++) begin
				sum0[i] <= {1'b0, req.ops.x[i*`WORD_BITS +: `WORD_BITS]}
					+ {1'b0, req.ops.y[i*`WORD_BITS +: `WORD_BITS]};
				sum1[i] <= {1'b0, req.ops.x[i*`WORD_BITS +: `WORD_BITS]}
					+ {1'b0, req.ops.y[i*`WORD_BITS +: `WORD_BITS]} + 1'b1;
			end
		end
		if (busy) begin
			sum.sum       <= sel_sum;
			sum.carry_out <= sel_carry;
		end
	end

	// Second cycle, carry ripples through the limb selects
	always_comb begin
		logic                c;
		logic [`WORD_BITS:0] limb;
		c = carry_in_q;
		for (int i = 0; i < `FIELD_WORDS; i++) begin
			limb = c ? sum1[i] : sum0[i];
			sel_sum[i*`WORD_BITS +: `WORD_BITS] = limb[`WORD_BITS-1:0];
			c = limb[`WORD_BITS];
		end
		sel_carry = c;
	end

endmodule

`default_nettype wire

// File: field_alu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "field_settings.svh"

module field_alu_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  field_pkg::field_op_t    op,
	input  field_pkg::field_word_t  a,
	input  field_pkg::field_word_t  b,
	output field_pkg::field_word_t  result,
	output logic                    done
);

	import field_pkg::*;

	logic          mul_start;
	operand_pair_t mul_ops;
	product_t      mul_product;
	logic          mul_done;
	logic          add_start;
	add_req_t      add_req;
	add_sum_t      add_sum;
	logic          add_done;
	logic          sub_start;
	operand_pair_t sub_ops;
	field_word_t   sub_diff;
	logic          sub_borrow;
	logic          sub_done;

	field_op_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.op          (op),
		.a           (a),
		.b           (b),
		.result      (result),
		.done        (done),
		.mul_start   (mul_start),
		.mul_ops     (mul_ops),
		.mul_product (mul_product),
		.mul_done    (mul_done),
		.add_start   (add_start),
		.add_req     (add_req),
		.add_sum     (add_sum),
		.add_done    (add_done),
		.sub_start   (sub_start),
		.sub_ops     (sub_ops),
		.sub_diff    (sub_diff),
		.sub_borrow  (sub_borrow),
		.sub_done    (sub_done)
	);

	word_multiplier u_mul (
		.clk     (clk),
		.rst     (rst),
		.start   (mul_start),
		.ops     (mul_ops),
		.product (mul_product),
		.done    (mul_done)
	);

	carry_select_adder u_add (
		.clk   (clk),
		.rst   (rst),
		.start (add_start),
		.req   (add_req),
		.sum   (add_sum),
		.done  (add_done)
	);

	borrow_select_subtractor u_sub (
		.clk    (clk),
		.rst    (rst),
		.start  (sub_start),
		.ops    (sub_ops),
		.diff   (sub_diff),
		.borrow (sub_borrow),
		.done   (sub_done)
	);

endmodule

`default_nettype wire

// File: field_op_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "field_settings.svh"

module field_op_ctrl (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,
	input  field_pkg::field_op_t      op,
	input  field_pkg::field_word_t    a,
	input  field_pkg::field_word_t    b,
	output field_pkg::field_word_t    result,
	output logic                      done,
	output logic                      mul_start,
	output field_pkg::operand_pair_t  mul_ops,
	input  field_pkg::product_t       mul_product,
	input  logic                      mul_done,
	output logic                      add_start,
	output field_pkg::add_req_t       add_req,
	input  field_pkg::add_sum_t       add_sum,
	input  logic                      add_done,
	output logic                      sub_start,
	output field_pkg::operand_pair_t  sub_ops,
	input  field_pkg::field_word_t    sub_diff,
	input  logic                      sub_borrow,
	input  logic                      sub_done
);

	import field_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE,
		S_RSVD,
		S_MUL_T,      // T = a * b
		S_MUL_M,      // m = T.lo * pinv
		S_MUL_MP,     // m * p
		S_ADD_LO,
		S_ADD_SUM,    // Sum to be reduced by p
		S_SUB_P,
		S_SUB_AB,
		S_ADD_P
	} state_t;

	state_t      state;
	product_t    t_q;
	product_t    mp_q;
	field_word_t u_q;
	logic        u_carry;
	logic        mul_ready;
	logic        add_ready;
	logic        sub_ready;

	// Unit done is stale while its start is still high
	assign mul_ready = mul_done && !mul_start;
	assign add_ready = add_done && !add_start;
	assign sub_ready = sub_done && !sub_start;

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= S_IDLE;
			done      <= 1'b0;
			mul_start <= 1'b0;
			add_start <= 1'b0;
			sub_start <= 1'b0;
		end else begin
			mul_start <= 1'b0;
			add_start <= 1'b0;
			sub_start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						done <= 1'b0;
						case (op)
							OP_MONT_MUL: begin
								mul_ops   <= '{x: a, y: b};
								mul_start <= 1'b1;
								state     <= S_MUL_T;
							end
							OP_MOD_ADD: begin
								add_req   <= '{ops: '{x: a, y: b}, carry_in: 1'b0};
								add_start <= 1'b1;
								state     <= S_ADD_SUM;
							end
							OP_MOD_SUB: begin
								sub_ops   <= '{x: a, y: b};
								sub_start <= 1'b1;
								state     <= S_SUB_AB;
							end
							default: state <= S_RSVD;
						endcase
					end
				end
				S_RSVD: begin
					result <= '0;
					done   <= 1'b1;
					state  <= S_IDLE;
				end
				// ====================
				// Montgomery reduction
				// ====================
				S_MUL_T: if (mul_ready) begin
					t_q       <= mul_product;
					mul_ops   <= '{x: mul_product.half.lo, y: `FIELD_PINV};
					mul_start <= 1'b1;
					state     <= S_MUL_M;
				end
				S_MUL_M: if (mul_ready) begin
					mul_ops   <= '{x: mul_product.half.lo, y: `FIELD_PRIME};
					mul_start <= 1'b1;
					state     <= S_MUL_MP;
				end
				S_MUL_MP: if (mul_ready) begin
					mp_q      <= mul_product;
					add_req   <= '{ops: '{x: t_q.half.lo, y: mul_product.half.lo}, carry_in: 1'b0};
					add_start <= 1'b1;
					state     <= S_ADD_LO;
				end
				S_ADD_LO: if (add_ready) begin
					// Low half sums to zero, only its carry moves up
					add_req   <= '{ops: '{x: t_q.half.hi, y: mp_q.half.hi},
						carry_in: add_sum.carry_out};
					add_start <= 1'b1;
					state     <= S_ADD_SUM;
				end
				// ====================
				// Final correction by p
				// ====================
				S_ADD_SUM: if (add_ready) begin
					u_q       <= add_sum.sum;
					u_carry   <= add_sum.carry_out;
					sub_ops   <= '{x: add_sum.sum, y: `FIELD_PRIME};
					sub_start <= 1'b1;
					state     <= S_SUB_P;
				end
				S_SUB_P: if (sub_ready) begin
					result <= (sub_borrow && !u_carry) ? u_q : sub_diff;
					done   <= 1'b1;
					state  <= S_IDLE;
				end
				S_SUB_AB: if (sub_ready) begin
					if (sub_borrow) begin
						add_req   <= '{ops: '{x: sub_diff, y: `FIELD_PRIME}, carry_in: 1'b0};
						add_start <= 1'b1;
						state     <= S_ADD_P;
					end else begin
						result <= sub_diff;
						done   <= 1'b1;
						state  <= S_IDLE;
					end
				end
				S_ADD_P: if (add_ready) begin
					result <= add_sum.sum;    // Carry out dropped
					done   <= 1'b1;
					state  <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: field_pkg.sv
`default_nettype none

`include "field_settings.svh"

package field_pkg;

	typedef enum logic [1:0] {
		OP_MONT_MUL = 2'd0,
		OP_MOD_ADD  = 2'd1,
		OP_MOD_SUB  = 2'd2    // 3 is reserved
	} field_op_t;

	typedef logic [`FIELD_BITS-1:0] field_word_t;

	typedef struct packed {
		field_word_t x;
		field_word_t y;
	} operand_pair_t;

	typedef struct packed {
		operand_pair_t ops;
		logic          carry_in;
	} add_req_t;

	typedef struct packed {
		field_word_t sum;
		logic        carry_out;
	} add_sum_t;

	typedef struct packed {
		field_word_t hi;
		field_word_t lo;
	} product_halves_t;

	// Double-width product, read whole or by halves
	typedef union packed {
		logic [2*`FIELD_BITS-1:0] whole;
		product_halves_t          half;
	} product_t;

endpackage

`default_nettype wire

// File: field_settings.svh
`ifndef FIELD_SETTINGS_SVH
`define FIELD_SETTINGS_SVH

// Operand and limb widths
`define FIELD_BITS  1024
`define WORD_BITS   32
`define FIELD_WORDS (`FIELD_BITS / `WORD_BITS)

// CSIDH-style prime p
`define FIELD_PRIME { \
	256'h0ece55ed427012a9d89dec879007ebd7216c22bc86f21a080683cf25db31ad5b, \
	256'hf06de2471cf9386e4d6c594a8ad82d2df811d9c419ec83297611ad4f90441c80, \
	256'h0978dbeed90a2b58b97c56d1de81ede56b317c5431541f40642aca4d5a313709, \
	256'hc2cab6a0e287f1bd514ba72cb8d89fd3a1d81eebbc3d344ddbe34c5460e36453}

// -p^-1 mod 2^FIELD_BITS
`define FIELD_PINV { \
	256'he6b14ff7a8473e0a0dd4b06020e7d66c69a7664077c881339e0ec706aceba3b2, \
	256'h2071fcf91a8e874db4ca0a3acd608970bc448a790ae4ead38440b17a6335f826, \
	256'ha93ab1dd3f816e35e6d7f7ff7198303c2107172bba71ff71b74d3be5b4035fb4, \
	256'h9cc0eff5aa616b6e393ac935721044ea900965ed4020071fd2c2c24160038025}

`endif

// File: flist.f
+incdir+.
field_pkg.sv
carry_select_adder.sv
borrow_select_subtractor.sv
word_multiplier.sv
field_op_ctrl.sv
field_alu_top.sv
tb_field_alu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the field ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f flist.f \
	--top-module tb_field_alu -o tb_field_alu > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_field_alu > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "STATUS: FAIL" "$SIM_LOG"; then
	echo "Simulation reported failure"
	exit 1
fi

exit 0

// File: tb_field_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "field_settings.svh"

module tb_field_alu;

	import field_pkg::*;

	localparam int          FB             = `FIELD_BITS;
	localparam int          TIMEOUT_CYCLES = 2000;
	localparam field_word_t PRIME          = `FIELD_PRIME;
	localparam field_word_t ONE            = {{(FB-1){1'b0}}, 1'b1};

	logic        clk;
	logic        rst;
	logic        start;
	field_op_t   op;
	field_word_t a;
	field_word_t b;
	field_word_t result;
	logic        done;
	integer      seed;
	int          err_count;

	field_alu_top dut0 (
		.clk    (clk),
		.rst    (rst),
		.start  (start),
		.op     (op),
		.a      (a),
		.b      (b),
		.result (result),
		.done   (done)
	);

	always #10 clk = ~clk;

	// ====================
	// Reference model
	// ====================
	function automatic field_word_t mod_add_model(input field_word_t x, input field_word_t y);
		logic [FB:0] s;
		s = {1'b0, x} + {1'b0, y};    // 1025-bit sum
		if (s >= {1'b0, PRIME})
			s = s - {1'b0, PRIME};
		return s[FB-1:0];
	endfunction

	function automatic field_word_t mod_sub_model(input field_word_t x, input field_word_t y);
		field_word_t d;
		if (x < y)
			d = x - y + PRIME;
		else
			d = x - y;
		return d;
	endfunction

	// Random field element, joined from 32-bit words and reduced mod p
	task automatic random_element(output field_word_t v);
		field_word_t raw;
		for (int i = 0; i < `FIELD_WORDS; i++)
			raw[i*`WORD_BITS +: `WORD_BITS] = $random(seed);
		v = raw % PRIME;
	endtask

	task automatic compare(input string name, input field_word_t exp, input field_word_t got);
		assert (got == exp) else begin
			$display("Error: %s expected %h actual %h", name, exp, got);
			err_count++;
		end
	endtask

	// ====================
	// DUT handshake
	// ====================
	task automatic issue_start(input string name, input field_op_t o,
		input field_word_t x, input field_word_t y);
		start = 1'b1;
		op    = o;
		a     = x;
		b     = y;
		@(posedge clk);
		#1;
		start = 1'b0;
		assert (done === 1'b0) else begin
			$display("%s: done did not fall on the edge after start", name);
			err_count++;
		end
	endtask

	task automatic wait_for_done(input string name, output logic ok);
		int cycles;
		cycles = 0;
		while (done !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		ok = (done === 1'b1);
		assert (ok) else begin
			$display("%s: no done within the timeout", name);
			err_count++;
		end
	endtask

	task automatic run_op(input string name, input field_op_t o,
		input field_word_t x, input field_word_t y, output logic ok);
		issue_start(name, o, x, y);
		wait_for_done(name, ok);
	endtask

	task automatic add_and_compare(input string name, input field_word_t x, input field_word_t y);
		logic ok;
		run_op(name, OP_MOD_ADD, x, y, ok);
		if (ok)
			compare(name, mod_add_model(x, y), result);
	endtask

	task automatic sub_and_compare(input string name, input field_word_t x, input field_word_t y);
		logic ok;
		run_op(name, OP_MOD_SUB, x, y, ok);
		if (ok)
			compare(name, mod_sub_model(x, y), result);
	endtask

	task automatic mont_and_compare(input string name, input field_word_t x, input field_word_t y);
		logic            ok;
		logic [2*FB-1:0] p_wide;
		logic [2*FB-1:0] lhs;
		logic [2*FB-1:0] rhs;
		run_op(name, OP_MONT_MUL, x, y, ok);
		if (ok) begin
			p_wide = {{FB{1'b0}}, PRIME};
			lhs    = {result, {FB{1'b0}}} % p_wide;    // result * R mod p
			rhs    = ({{FB{1'b0}}, x} * {{FB{1'b0}}, y}) % p_wide;
			assert (result < PRIME) else begin
				$display("Error: %s expected below %h actual %h", name, PRIME, result);
				err_count++;
			end
			compare(name, rhs[FB-1:0], lhs[FB-1:0]);
		end
	endtask

	// ====================
	// Tests
	// ====================
	task automatic reset_behavior();
		repeat (10) begin
			@(posedge clk);
			#1;
			assert (done === 1'b0) else begin
				$display("done was high during reset");
				err_count++;
			end
		end
		rst = 1'b0;
		@(posedge clk);
		#1;
		assert (done === 1'b0) else begin
			$display("done was high on the first edge after reset");
			err_count++;
		end
		add_and_compare("reset_first_op", ONE, ONE);
	endtask

	task automatic mod_add_tests();
		field_word_t x;
		field_word_t y;
		for (int i = 0; i < 20; i++) begin
			random_element(x);
			random_element(y);
			add_and_compare("mod_add_random", x, y);
		end
		add_and_compare("mod_add_max_max", PRIME - ONE, PRIME - ONE);
		add_and_compare("mod_add_zero", '0, '0);
		add_and_compare("mod_add_wrap", PRIME - ONE, ONE);
	endtask

	task automatic mod_sub_tests();
		field_word_t x;
		field_word_t y;
		for (int i = 0; i < 20; i++) begin
			random_element(x);
			random_element(y);
			sub_and_compare("mod_sub_random", x, y);
		end
		sub_and_compare("mod_sub_equal", x, x);
		if (x < y)    // Smaller operand first
			sub_and_compare("mod_sub_less", x, y);
		else
			sub_and_compare("mod_sub_less", y, x);
		sub_and_compare("mod_sub_zero_max", '0, PRIME - ONE);
	endtask

	task automatic mont_mul_tests();
		field_word_t x;
		field_word_t y;
		for (int i = 0; i < 10; i++) begin
			random_element(x);
			random_element(y);
			mont_and_compare("mont_mul_random", x, y);
		end
		mont_and_compare("mont_mul_zero", '0, x);
		mont_and_compare("mont_mul_one", ONE, x);
		mont_and_compare("mont_mul_one_one", ONE, ONE);
	endtask

	// Next start goes in the cycle after done rises
	task automatic back_to_back_tests();
		field_word_t x;
		field_word_t y;
		logic        ok;
		random_element(x);
		random_element(y);
		add_and_compare("b2b_first_add", x, y);
		issue_start("b2b_sub", OP_MOD_SUB, x, y);
		compare("b2b_hold_add", mod_add_model(x, y), result);
		wait_for_done("b2b_sub", ok);
		if (ok)
			compare("b2b_sub", mod_sub_model(x, y), result);
		issue_start("b2b_add", OP_MOD_ADD, y, x);
		compare("b2b_hold_sub", mod_sub_model(x, y), result);
		wait_for_done("b2b_add", ok);
		if (ok)
			compare("b2b_add", mod_add_model(y, x), result);
	endtask

	initial begin
		seed      = 36;
		err_count = 0;
		clk       = 1'b0;
		rst       = 1'b1;
		start     = 1'b0;
		op        = OP_MOD_ADD;
		a         = '0;
		b         = '0;
		reset_behavior();
		mod_add_tests();
		mod_sub_tests();
		mont_mul_tests();
		back_to_back_tests();
		$display("Run complete with %0d errors", err_count);
		if (err_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: word_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "field_settings.svh"

module word_multiplier (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,
	input  field_pkg::operand_pair_t  ops,
	output field_pkg::product_t       product,
	output logic                      done
);

	localparam int CNT_BITS = $clog2(`FIELD_WORDS);

	logic [`FIELD_BITS-1:0]             x_q;
	logic [`FIELD_BITS-1:0]             y_q;     // Shifts down one digit per step
	logic [CNT_BITS-1:0]                digit_cnt;
	logic                               busy;
	logic                               last_digit;
	logic [`FIELD_BITS+`WORD_BITS-1:0]  partial;
	logic [2*`FIELD_BITS-1:0]           partial_at_pos;

	// ====================
	// One digit of y per cycle
	// ====================
	assign partial = x_q * y_q[`WORD_BITS-1:0];
	assign partial_at_pos = {{(`FIELD_BITS-`WORD_BITS){1'b0}}, partial}
		<< (digit_cnt * `WORD_BITS);
	assign last_digit = (digit_cnt == CNT_BITS'(`FIELD_WORDS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else if (start) begin
			busy <= 1'b1;
			done <= 1'b0;
		end else if (busy && last_digit) begin
			busy <= 1'b0;
			done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			x_q           <= ops.x;
			y_q           <= ops.y;
			digit_cnt     <= '0;
			product.whole <= '0;
		end else if (busy) begin
			product.whole <= product.whole + partial_at_pos;
			y_q           <= y_q >> `WORD_BITS;
			digit_cnt     <= digit_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire
